/* hdl/cpu_pkg.sv */
`default_nettype none

// Instruction encodings, bit 15 first:
//   ALU_RR   opcode | alu_op | rd | rs     rd = rd op rs
//   ALU_IMM  opcode | rd | imm8            rd = rd + sext(imm8), flags updated
//   LDI      opcode | rd | imm8            rd = zext(imm8)
//   BR       opcode | cond | imm8          pc = pc + 1 + sext(imm8) when cond holds
//   JMP      opcode | unused | imm8        pc = imm8
//   IN/OUT   opcode | rd | imm8            imm8 is the I/O address
// The low three bits of cond mask {c, z, n} and bit 3 inverts the test.
package cpu_pkg;

    localparam int WORD_BITS      = 16;
    localparam int REG_BITS       = 4;
    localparam int NUM_REGS       = 1 << REG_BITS;
    localparam int PROG_BITS      = 8;
    localparam int PROG_WORDS     = 1 << PROG_BITS;
    localparam int IO_ADDR_BITS   = 8;
    localparam int AXIL_ADDR_BITS = 8;

    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [REG_BITS-1:0]     reg_idx_t;
    typedef logic [PROG_BITS-1:0]    pc_t;
    typedef logic [IO_ADDR_BITS-1:0] io_addr_t;

    typedef enum logic [3:0] {
        OP_ALU_RR  = 4'h0,
        OP_ALU_IMM = 4'h1,
        OP_LDI     = 4'h2,
        OP_BR      = 4'h3,
        OP_JMP     = 4'h4,
        OP_IN      = 4'h5,
        OP_OUT     = 4'h6,
        OP_HLT     = 4'h7,
        OP_NOP     = 4'h8
    } opcode_e;

    // CMP and TEST only update the flags.
    typedef enum logic [3:0] {
        MOV, ADD, ADC, SUB, SBC, CMP, AND, OR,
        XOR, TEST, INC, DEC, NOT, NEG, SHL, SHR
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs;
    } instr_rr_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        logic [7:0]  imm8;
    } instr_imm_t;

    typedef union packed {
        instr_rr_t  rr;
        instr_imm_t imm;
    } instr_u;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
    } busy_rd_t;

    typedef struct packed {
        logic       valid;
        opcode_e    opcode;
        alu_op_e    alu_op;
        reg_idx_t   rd;
        word_t      operand_a;
        word_t      operand_b;
        logic [7:0] imm8;
        pc_t        pc;
    } dec_exe_t;

    typedef struct packed {
        logic     valid;
        opcode_e  opcode;
        reg_idx_t rd;
        word_t    result;
        logic     we;
        io_addr_t io_addr;
    } exe_io_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic [AXIL_ADDR_BITS-1:0] addr;
        logic [2:0]                prot;
    } axil_addr_t;

    typedef axil_addr_t axil_aw_t;
    typedef axil_addr_t axil_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] strb;
    } axil_w_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  wire logic            clk,
    input  wire logic            nreset,
    input  wire logic            prog_we,
    input  wire cpu_pkg::pc_t    prog_addr,
    input  wire cpu_pkg::word_t  prog_data,
    input  wire logic            stall,
    input  wire logic            redirect,
    input  wire cpu_pkg::pc_t    redirect_pc,
    input  wire logic            halt,
    output logic                 valid,
    output cpu_pkg::instr_u      instr,
    output cpu_pkg::pc_t         pc
);
    import cpu_pkg::*;

    word_t prog_ram [PROG_WORDS];
    pc_t   fetch_pc;
    logic  advance;

    assign advance = !halt && !redirect && !stall;

    always_ff @(posedge clk) begin
        if (prog_we)
            prog_ram[prog_addr] <= prog_data;
    end

    // A redirect wins over a stall and kills the word already read.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            fetch_pc <= '0;
            valid <= 1'b0;
        end else if (!halt) begin
            if (redirect) begin
                fetch_pc <= redirect_pc;
                valid <= 1'b0;
            end else if (!stall) begin
                fetch_pc <= fetch_pc + 1'b1;
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            instr <= instr_u'(prog_ram[fetch_pc]);
            pc <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              nreset,
    input  wire logic              in_valid,
    input  wire cpu_pkg::instr_u   instr,
    input  wire cpu_pkg::pc_t      pc,
    input  wire logic              flush,
    input  wire cpu_pkg::busy_rd_t exe_busy_rd,
    input  wire cpu_pkg::busy_rd_t io_busy_rd,
    input  wire cpu_pkg::wb_t      wb,
    input  wire logic              io_busy,
    output logic                   stall,
    output cpu_pkg::dec_exe_t      out
);
    import cpu_pkg::*;

    word_t      regs [NUM_REGS];
    instr_rr_t  rr;
    instr_imm_t im;
    opcode_e    op;
    reg_idx_t   rd_idx;
    logic       reads_rd;
    logic       reads_rs;
    logic       raw_rd;
    logic       raw_rs;
    word_t      operand_b;
    alu_op_e    alu_op;

    function automatic logic hit(busy_rd_t busy, reg_idx_t idx);
        return busy.valid && busy.rd == idx;
    endfunction

    assign rr = instr.rr;
    assign im = instr.imm;
    assign op = rr.opcode;

    always_ff @(posedge clk) begin
        if (wb.valid)
            regs[wb.rd] <= wb.data;
    end

    // Only the register-register form keeps rd in the middle nibble.
    always_comb begin
        rd_idx = (op == OP_ALU_RR) ? rr.rd : im.rd;
        reads_rd = op inside {OP_ALU_RR, OP_ALU_IMM, OP_OUT};
        reads_rs = op == OP_ALU_RR;
        raw_rd = reads_rd && (hit(exe_busy_rd, rd_idx) || hit(io_busy_rd, rd_idx));
        raw_rs = reads_rs && (hit(exe_busy_rd, rr.rs) || hit(io_busy_rd, rr.rs));
        stall = in_valid && (raw_rd || raw_rs);
    end

    always_comb begin
        case (op)
            OP_ALU_RR:         operand_b = regs[rr.rs];
            OP_ALU_IMM, OP_BR: operand_b = word_t'(signed'(im.imm8));
            default:           operand_b = word_t'(im.imm8);
        endcase
        case (op)
            OP_ALU_RR:  alu_op = rr.alu_op;
            OP_ALU_IMM: alu_op = ADD;
            default:    alu_op = MOV;
        endcase
    end

    // A stalled instruction stays in place and a bubble goes to execute.
    always_ff @(posedge clk) begin
        if (!nreset)
            out.valid <= 1'b0;
        else if (!io_busy)
            out.valid <= in_valid && !flush && !stall;
    end

    always_ff @(posedge clk) begin
        if (!io_busy) begin
            out.opcode <= op;
            out.alu_op <= alu_op;
            out.rd <= rd_idx;
            out.operand_a <= regs[rd_idx];
            out.operand_b <= operand_b;
            out.imm8 <= im.imm8;
            out.pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire logic              clk,
    input  wire logic              nreset,
    input  wire cpu_pkg::dec_exe_t in,
    input  wire logic              io_busy,
    output cpu_pkg::exe_io_t       out,
    output cpu_pkg::busy_rd_t      busy_rd,
    output logic                   redirect,
    output cpu_pkg::pc_t           redirect_pc
);
    import cpu_pkg::*;

    logic  c, z, n;
    logic  c_next;
    logic  cin;
    word_t a, b;
    word_t res;
    logic  is_alu;
    logic  writes;
    logic  cond_pass;

    assign a = in.operand_a;
    assign b = in.operand_b;
    assign is_alu = in.opcode inside {OP_ALU_RR, OP_ALU_IMM};

    always_comb begin
        cin = c && (in.alu_op inside {ADC, SBC});
        c_next = c;
        res = a;
        case (in.alu_op)
            MOV:           res = b;
            ADD, ADC:      {c_next, res} = {1'b0, a} + {1'b0, b} + {{WORD_BITS{1'b0}}, cin};
            SUB, SBC, CMP: {c_next, res} = {1'b0, a} - {1'b0, b} - {{WORD_BITS{1'b0}}, cin};
            AND, TEST:     res = a & b;
            OR:            res = a | b;
            XOR:           res = a ^ b;
            INC:           res = a + 1'b1;
            DEC:           res = a - 1'b1;
            NOT:           res = ~a;
            NEG:           res = -a;
            SHL:           {c_next, res} = {a, 1'b0};
            SHR:           {res, c_next} = {1'b0, a};
            default:       res = a;
        endcase
    end

    always_comb begin
        case (in.opcode)
            OP_ALU_RR:               writes = !(in.alu_op inside {CMP, TEST});
            OP_ALU_IMM, OP_LDI, OP_IN: writes = 1'b1;
            default:                 writes = 1'b0;
        endcase
    end

    // For a branch the rd field holds the condition.
    assign cond_pass = (|(in.rd[2:0] & {c, z, n})) ^ in.rd[3];

    assign redirect = in.valid && !io_busy
                      && ((in.opcode == OP_BR && cond_pass) || in.opcode == OP_JMP);
    assign redirect_pc = (in.opcode == OP_JMP) ? pc_t'(in.operand_b)
                                               : in.pc + 1'b1 + pc_t'(in.operand_b);

    assign busy_rd.valid = in.valid && writes;
    assign busy_rd.rd = in.rd;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            c <= 1'b0;
            z <= 1'b0;
            n <= 1'b0;
        end else if (!io_busy && in.valid && is_alu) begin
            c <= c_next;
            z <= res == '0;
            n <= res[WORD_BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset)
            out.valid <= 1'b0;
        else if (!io_busy)
            out.valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (!io_busy) begin
            out.opcode <= in.opcode;
            out.rd <= in.rd;
            out.result <= is_alu ? res : (in.opcode == OP_OUT) ? a : b;
            out.we <= writes;
            out.io_addr <= io_addr_t'(in.imm8);
        end
    end

endmodule

`default_nettype wire

/* hdl/io_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module io_stage (
    input  wire logic              clk,
    input  wire logic              nreset,
    input  wire cpu_pkg::exe_io_t  in,
    output logic                   busy,
    output cpu_pkg::busy_rd_t      busy_rd,
    output cpu_pkg::wb_t           wb,
    output logic                   halted,
    output cpu_pkg::axil_aw_t      aw,
    output logic                   aw_valid,
    input  wire logic              aw_ready,
    output cpu_pkg::axil_w_t       w,
    output logic                   w_valid,
    input  wire logic              w_ready,
    input  wire cpu_pkg::axil_b_t  b,
    input  wire logic              b_valid,
    output logic                   b_ready,
    output cpu_pkg::axil_ar_t      ar,
    output logic                   ar_valid,
    input  wire logic              ar_ready,
    input  wire cpu_pkg::axil_r_t  r,
    input  wire logic              r_valid,
    output logic                   r_ready
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {IDLE, WRITE, WAIT_B, READ, WAIT_R} io_state_e;

    io_state_e state;
    logic      aw_done, w_done;
    logic      aw_sent, w_sent;
    logic      live, is_io;
    logic      done_now, bus_err;

    // Nothing after HLT takes effect.
    assign live = in.valid && !halted;
    assign is_io = in.opcode inside {OP_IN, OP_OUT};
    assign done_now = (state == WAIT_B && b_valid) || (state == WAIT_R && r_valid);
    assign bus_err = (state == WAIT_B && b_valid && b.resp[1])
                     || (state == WAIT_R && r_valid && r.resp[1]);
    assign busy = live && is_io && !done_now;

    assign busy_rd.valid = live && in.we;
    assign busy_rd.rd = in.rd;

    assign wb.valid = live && in.we && (in.opcode != OP_IN || (state == WAIT_R && r_valid));
    assign wb.rd = in.rd;
    assign wb.data = (in.opcode == OP_IN) ? r.data : in.result;

    assign aw.addr = AXIL_ADDR_BITS'(in.io_addr);
    assign aw.prot = 3'b000;
    assign ar = aw;
    assign w.data = in.result;
    assign w.strb = 2'b11;

    assign aw_valid = state == WRITE && !aw_done;
    assign w_valid = state == WRITE && !w_done;
    assign b_ready = state == WAIT_B;
    assign ar_valid = state == READ;
    assign r_ready = state == WAIT_R;

    assign aw_sent = aw_done || (aw_valid && aw_ready);
    assign w_sent = w_done || (w_valid && w_ready);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= IDLE;
            aw_done <= 1'b0;
            w_done <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                IDLE: if (live && is_io) state <= (in.opcode == OP_OUT) ? WRITE : READ;
                WRITE: begin
                    // Address and data may be accepted in different cycles.
                    if (aw_sent && w_sent) begin
                        state <= WAIT_B;
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                    end else begin
                        aw_done <= aw_sent;
                        w_done <= w_sent;
                    end
                end
                WAIT_B: if (b_valid) state <= IDLE;
                READ:   if (ar_ready) state <= WAIT_R;
                WAIT_R: if (r_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
            // An error response from a peripheral stops the core like HLT does.
            if ((live && in.opcode == OP_HLT) || bus_err)
                halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  wire logic              clk,
    input  wire logic              nreset,
    input  wire logic              prog_we,
    input  wire cpu_pkg::pc_t      prog_addr,
    input  wire cpu_pkg::word_t    prog_data,
    output cpu_pkg::axil_aw_t      aw,
    output logic                   aw_valid,
    input  wire logic              aw_ready,
    output cpu_pkg::axil_w_t       w,
    output logic                   w_valid,
    input  wire logic              w_ready,
    input  wire cpu_pkg::axil_b_t  b,
    input  wire logic              b_valid,
    output logic                   b_ready,
    output cpu_pkg::axil_ar_t      ar,
    output logic                   ar_valid,
    input  wire logic              ar_ready,
    input  wire cpu_pkg::axil_r_t  r,
    input  wire logic              r_valid,
    output logic                   r_ready,
    output logic                   halted
);
    import cpu_pkg::*;

    logic     f_valid;
    instr_u   f_instr;
    pc_t      f_pc;
    logic     dec_stall;
    logic     fetch_stall;
    dec_exe_t dec_out;
    exe_io_t  exe_out;
    busy_rd_t exe_busy_rd;
    busy_rd_t io_busy_rd;
    wb_t      wb;
    logic     redirect;
    pc_t      redirect_pc;
    logic     io_busy;

    assign fetch_stall = dec_stall || io_busy;

    fetch_stage u_fetch (
        .clk, .nreset, .prog_we, .prog_addr, .prog_data,
        .stall(fetch_stall), .redirect, .redirect_pc, .halt(halted),
        .valid(f_valid), .instr(f_instr), .pc(f_pc)
    );

    decode_stage u_decode (
        .clk, .nreset, .in_valid(f_valid), .instr(f_instr), .pc(f_pc),
        .flush(redirect), .exe_busy_rd, .io_busy_rd, .wb, .io_busy,
        .stall(dec_stall), .out(dec_out)
    );

    execute_stage u_execute (
        .clk, .nreset, .in(dec_out), .io_busy,
        .out(exe_out), .busy_rd(exe_busy_rd), .redirect, .redirect_pc
    );

    io_stage u_io (
        .clk, .nreset, .in(exe_out),
        .busy(io_busy), .busy_rd(io_busy_rd), .wb, .halted,
        .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready, .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready
    );

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int RUN_LIMIT = 4000;
    localparam int QUIET_CYCLES = 50;

    logic     clk;
    logic     nreset;
    logic     prog_we;
    pc_t      prog_addr;
    word_t    prog_data;
    axil_aw_t aw;
    logic     aw_valid;
    logic     aw_ready = 1'b0;
    axil_w_t  w;
    logic     w_valid;
    logic     w_ready = 1'b0;
    axil_b_t  b = '0;
    logic     b_valid = 1'b0;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     ar_ready = 1'b0;
    axil_r_t  r = '0;
    logic     r_valid = 1'b0;
    logic     r_ready;
    logic     halted;

    // The peripheral keeps a read data table and logs every completed transaction.
    word_t    io_table [256];
    axil_aw_t got_aw [$];
    axil_w_t  got_w [$];
    axil_ar_t got_ar [$];
    int       read_count;
    axil_aw_t aw_hold;
    axil_w_t  w_hold;
    axil_ar_t ar_hold;
    logic     aw_have = 1'b0;
    logic     w_have = 1'b0;
    logic     ar_have = 1'b0;

    word_t    prog [$];
    axil_aw_t want_aw [$];
    axil_w_t  want_w [$];

    cpu_top DUT (
        .clk, .nreset, .prog_we, .prog_addr, .prog_data,
        .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready, .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready, .halted
    );

    always #5 clk = ~clk;

    // AXI4-Lite peripheral with random ready and response delays.
    initial begin : peripheral
        void'($urandom(32'he22d5fae));
        forever begin
            @(posedge clk);
            if (!nreset) begin
                aw_ready <= 1'b0;
                w_ready <= 1'b0;
                ar_ready <= 1'b0;
                b_valid <= 1'b0;
                r_valid <= 1'b0;
                aw_have <= 1'b0;
                w_have <= 1'b0;
                ar_have <= 1'b0;
            end else begin
                aw_ready <= ($urandom % 3) == 0;
                w_ready <= ($urandom % 3) == 0;
                ar_ready <= ($urandom % 3) == 0;
                if (aw_valid && aw_ready) begin
                    aw_have <= 1'b1;
                    aw_hold <= aw;
                end
                if (w_valid && w_ready) begin
                    w_have <= 1'b1;
                    w_hold <= w;
                end
                if (aw_have && w_have && !b_valid && ($urandom % 2) == 0) begin
                    got_aw.push_back(aw_hold);
                    got_w.push_back(w_hold);
                    aw_have <= 1'b0;
                    w_have <= 1'b0;
                    b_valid <= 1'b1;
                end
                if (b_valid && b_ready)
                    b_valid <= 1'b0;
                if (ar_valid && ar_ready) begin
                    ar_have <= 1'b1;
                    ar_hold <= ar;
                    got_ar.push_back(ar);
                    read_count++;
                end
                if (ar_have && !r_valid && ($urandom % 2) == 0) begin
                    r <= '{data: io_table[ar_hold.addr], resp: 2'b00};
                    r_valid <= 1'b1;
                    ar_have <= 1'b0;
                end
                if (r_valid && r_ready)
                    r_valid <= 1'b0;
            end
        end
    end

    function automatic word_t enc_rr(alu_op_e op, reg_idx_t rd, reg_idx_t rs);
        return {OP_ALU_RR, op, rd, rs};
    endfunction

    function automatic word_t enc_imm(opcode_e op, logic [3:0] field, logic [7:0] imm8);
        return {op, field, imm8};
    endfunction

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping after the first error.");
    endtask

    task automatic check_write(string test, int idx, axil_aw_t exp_aw, axil_w_t exp_w,
                               axil_aw_t act_aw, axil_w_t act_w);
        if (exp_aw !== act_aw || exp_w !== act_w) begin
            $display("[ERROR] %s: write %0d expected aw %h w %h, actual aw %h w %h",
                     test, idx, exp_aw, exp_w, act_aw, act_w);
            stop_failed();
        end
    endtask

    task automatic check_read(string test, int idx, axil_ar_t exp, axil_ar_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: read %0d expected ar %h, actual ar %h",
                     test, idx, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_word(string test, word_t exp, word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_halted(string test, logic exp, logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected halted %b, actual %b", test, exp, act);
            stop_failed();
        end
    endtask

    task automatic start_test();
        prog.delete();
        want_aw.delete();
        want_w.delete();
    endtask

    task automatic expect_write(io_addr_t addr, word_t data);
        want_aw.push_back('{addr: addr, prot: 3'b000});
        want_w.push_back('{data: data, strb: 2'b11});
    endtask

    // Loads the whole RAM under reset; unused words are HLT tagged with their address.
    task automatic run_program(string test);
        int cycles;
        @(posedge clk);
        nreset <= 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= pc_t'(i);
            prog_data <= (i < prog.size()) ? prog[i] : {OP_HLT, 4'h0, 8'(i)};
        end
        @(posedge clk);
        prog_we <= 1'b0;
        got_aw.delete();
        got_w.delete();
        got_ar.delete();
        read_count = 0;
        repeat (3) @(posedge clk);
        nreset <= 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: test %s did not halt within %0d cycles.", test, RUN_LIMIT);
            stop_failed();
        end
    endtask

    task automatic check_writes(string test);
        check_word({test, " write count"}, word_t'(want_aw.size()), word_t'(got_aw.size()));
        for (int i = 0; i < want_aw.size(); i++)
            check_write(test, i, want_aw[i], want_w[i], got_aw[i], got_w[i]);
    endtask

    task automatic test_alu();
        alu_op_e ops [11];
        word_t   a;
        word_t   bv;
        word_t   res;
        ops = '{ADD, SUB, AND, OR, XOR, INC, DEC, NOT, NEG, SHL, SHR};
        a = 16'h005A;
        bv = 16'h0033;
        start_test();
        prog.push_back(enc_imm(OP_LDI, 4'd1, a[7:0]));
        prog.push_back(enc_imm(OP_LDI, 4'd2, bv[7:0]));
        for (int i = 0; i < 11; i++) begin
            prog.push_back(enc_rr(MOV, 4'd3, 4'd1));
            prog.push_back(enc_rr(ops[i], 4'd3, 4'd2));
            prog.push_back(enc_imm(OP_OUT, 4'd3, 8'h10 + 8'(i)));
            case (ops[i])
                ADD:     res = a + bv;
                SUB:     res = a - bv;
                AND:     res = a & bv;
                OR:      res = a | bv;
                XOR:     res = a ^ bv;
                INC:     res = a + 16'd1;
                DEC:     res = a - 16'd1;
                NOT:     res = ~a;
                NEG:     res = 16'd0 - a;
                SHL:     res = {a[14:0], 1'b0};
                default: res = {1'b0, a[15:1]};
            endcase
            expect_write(8'h10 + 8'(i), res);
        end
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        run_program("alu");
        check_writes("alu");
    endtask

    task automatic test_carry();
        logic [16:0] wide;
        logic        carry;
        word_t       diff;
        word_t       borrowed;
        start_test();
        prog.push_back(enc_imm(OP_LDI, 4'd1, 8'h00));
        prog.push_back(enc_rr(NOT, 4'd1, 4'd1));
        prog.push_back(enc_imm(OP_LDI, 4'd2, 8'h02));
        prog.push_back(enc_rr(ADD, 4'd1, 4'd2));
        prog.push_back(enc_imm(OP_LDI, 4'd4, 8'h10));
        prog.push_back(enc_imm(OP_LDI, 4'd5, 8'h20));
        prog.push_back(enc_rr(ADC, 4'd4, 4'd5));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h20));
        prog.push_back(enc_imm(OP_OUT, 4'd4, 8'h21));
        prog.push_back(enc_imm(OP_LDI, 4'd6, 8'h01));
        prog.push_back(enc_imm(OP_LDI, 4'd7, 8'h02));
        prog.push_back(enc_rr(SUB, 4'd6, 4'd7));
        prog.push_back(enc_imm(OP_LDI, 4'd8, 8'h30));
        prog.push_back(enc_imm(OP_LDI, 4'd9, 8'h10));
        prog.push_back(enc_rr(SBC, 4'd8, 4'd9));
        prog.push_back(enc_imm(OP_OUT, 4'd8, 8'h23));
        prog.push_back(enc_rr(ADC, 4'd8, 4'd9));
        prog.push_back(enc_imm(OP_OUT, 4'd6, 8'h22));
        prog.push_back(enc_imm(OP_OUT, 4'd8, 8'h24));
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        // Carry comes from bit 16 of the widened sum or difference.
        wide = {1'b0, ~16'h0000} + 17'h00002;
        carry = wide[16];
        expect_write(8'h20, wide[15:0]);
        wide = 17'h00010 + 17'h00020 + {16'd0, carry};
        expect_write(8'h21, wide[15:0]);
        wide = 17'h00001 - 17'h00002;
        carry = wide[16];
        diff = wide[15:0];
        wide = 17'h00030 - 17'h00010 - {16'd0, carry};
        carry = wide[16];
        borrowed = wide[15:0];
        expect_write(8'h23, borrowed);
        wide = {1'b0, borrowed} + 17'h00010 + {16'd0, carry};
        expect_write(8'h22, diff);
        expect_write(8'h24, wide[15:0]);
        run_program("carry");
        check_writes("carry");
    endtask

    task automatic test_branch();
        start_test();
        prog.push_back(enc_imm(OP_LDI, 4'd1, 8'd3));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h20));
        prog.push_back(enc_rr(DEC, 4'd1, 4'd1));
        prog.push_back(enc_imm(OP_BR, 4'hA, 8'hFD));
        prog.push_back(enc_imm(OP_BR, 4'h2, 8'h01));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h2F));
        prog.push_back(enc_imm(OP_BR, 4'h4, 8'h01));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h21));
        prog.push_back(enc_imm(OP_JMP, 4'd0, 8'd10));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h2E));
        prog.push_back(enc_imm(OP_BR, 4'h8, 8'h01));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h2D));
        prog.push_back(enc_imm(OP_LDI, 4'd3, 8'h42));
        prog.push_back(enc_imm(OP_OUT, 4'd3, 8'h22));
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        // The loop body writes the counter before each decrement.
        for (int v = 3; v > 0; v--)
            expect_write(8'h20, word_t'(v));
        expect_write(8'h21, 16'h0000);
        expect_write(8'h22, 16'h0042);
        run_program("branch");
        check_writes("branch");
    endtask

    task automatic test_hazard();
        word_t v1;
        word_t v2;
        word_t v3;
        start_test();
        prog.push_back(enc_imm(OP_LDI, 4'd1, 8'd5));
        prog.push_back(enc_imm(OP_ALU_IMM, 4'd1, 8'd3));
        prog.push_back(enc_rr(MOV, 4'd2, 4'd1));
        prog.push_back(enc_rr(ADD, 4'd2, 4'd1));
        prog.push_back(enc_rr(SHL, 4'd2, 4'd2));
        prog.push_back(enc_rr(MOV, 4'd3, 4'd2));
        prog.push_back(enc_rr(SUB, 4'd3, 4'd1));
        prog.push_back(enc_imm(OP_ALU_IMM, 4'd3, 8'hFC));
        prog.push_back(enc_imm(OP_OUT, 4'd3, 8'h30));
        prog.push_back(enc_imm(OP_OUT, 4'd2, 8'h31));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h32));
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        v1 = 16'd5 + 16'd3;
        v2 = v1 + v1;
        v2 = v2 << 1;
        v3 = v2 - v1;
        v3 = v3 + 16'hFFFC;
        expect_write(8'h30, v3);
        expect_write(8'h31, v2);
        expect_write(8'h32, v1);
        run_program("hazard");
        check_writes("hazard");
    endtask

    task automatic test_in();
        start_test();
        prog.push_back(enc_imm(OP_IN, 4'd1, 8'h40));
        prog.push_back(enc_imm(OP_IN, 4'd2, 8'h41));
        prog.push_back(enc_rr(ADD, 4'd1, 4'd2));
        prog.push_back(enc_imm(OP_IN, 4'd3, 8'h42));
        prog.push_back(enc_rr(ADD, 4'd1, 4'd3));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h50));
        prog.push_back(enc_imm(OP_OUT, 4'd2, 8'h51));
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        expect_write(8'h50, io_table[8'h40] + io_table[8'h41] + io_table[8'h42]);
        expect_write(8'h51, io_table[8'h41]);
        run_program("in");
        check_word("in read count", 16'd3, word_t'(read_count));
        for (int i = 0; i < 3; i++)
            check_read("in", i, '{addr: 8'h40 + 8'(i), prot: 3'b000}, got_ar[i]);
        check_writes("in");
    endtask

    task automatic test_halt();
        start_test();
        prog.push_back(enc_imm(OP_LDI, 4'd1, 8'h11));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h60));
        prog.push_back(enc_imm(OP_HLT, 4'd0, 8'h00));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h61));
        prog.push_back(enc_imm(OP_LDI, 4'd1, 8'h22));
        prog.push_back(enc_imm(OP_OUT, 4'd1, 8'h62));
        expect_write(8'h60, 16'h0011);
        run_program("halt");
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_halted("halt", 1'b1, halted);
            if (aw_valid || w_valid || ar_valid) begin
                $display("The core started an AXI transaction after it halted.");
                stop_failed();
            end
        end
        check_word("halt read count", 16'd0, word_t'(read_count));
        check_writes("halt");
    endtask

    initial begin
        clk = 1'b0;
        nreset = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_count = 0;
        for (int i = 0; i < 256; i++)
            io_table[i] = word_t'(i * 291 + 64);
        test_alu();
        test_carry();
        test_branch();
        test_hazard();
        test_in();
        test_halt();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/io_stage.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := cpu_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)

check: run
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Simulation failed."; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass message in $(LOG)."; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
